//--- compile.f
+incdir+include
rtl/aes_pkg.sv
rtl/aes_key_memory.sv
rtl/aes_encryption.sv
rtl/aes_decryption.sv
rtl/aes_core.sv
bench/aes_core_assertions.sv
bench/aes_core_tb.sv

//--- Bender.yml
package:
  name: aes128_core

export_include_dirs:
  - include

sources:
  - files:
      - rtl/aes_pkg.sv
      - rtl/aes_key_memory.sv
      - rtl/aes_encryption.sv
      - rtl/aes_decryption.sv
      - rtl/aes_core.sv
  - target: test
    files:
      - bench/aes_core_assertions.sv
      - bench/aes_core_tb.sv

//--- bench/aes_core_tb.sv
`timescale 1ns/100ps
`include "aes_defines.svh"

module aes_core_tb;

  // 2 known-answer encryptions, 2 decryptions, 20 round trips, 2 mode checks
  localparam int NUM_OPS = 46;
  // watchdog limit in ns, 100 ns per cycle
  localparam int TIMEOUT_NS = (NUM_OPS * 30 + 100) * 100;

  // appendix vectors of the standard
  localparam aes_pkg::aes_block_t KEY_A = 128'h000102030405060708090a0b0c0d0e0f;
  localparam aes_pkg::aes_block_t PT_A  = 128'h00112233445566778899aabbccddeeff;
  localparam aes_pkg::aes_block_t CT_A  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
  localparam aes_pkg::aes_block_t KEY_B = 128'h2b7e151628aed2a6abf7158809cf4f3c;
  localparam aes_pkg::aes_block_t PT_B  = 128'h3243f6a8885a308d313198a2e0370734;
  localparam aes_pkg::aes_block_t CT_B  = 128'h3925841d02dc09fbdc118597196a0b32;

  logic                clk_in;
  logic                rst_in;
  logic                mode_in;
  logic                init_in;
  aes_pkg::aes_block_t data_in;
  aes_pkg::aes_block_t key_in;
  aes_pkg::aes_block_t data_out;
  logic                valid_out;

  int data_errors;

  aes_core i_dut (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .mode_in   (mode_in),
    .init_in   (init_in),
    .data_in   (data_in),
    .key_in    (key_in),
    .data_out  (data_out),
    .valid_out (valid_out)
  );

  // 100 ns period
  always #50 clk_in = ~clk_in;

  // ========================================
  // helpers
  // ========================================
  function automatic aes_pkg::aes_block_t random_block();
    return {$urandom, $urandom, $urandom, $urandom};
  endfunction

  // one operation, init on a falling edge, result taken mid-cycle
  task automatic run_block(input string name, input logic mode,
                           input aes_pkg::aes_block_t key, input aes_pkg::aes_block_t data,
                           input logic check_en, input aes_pkg::aes_block_t expected,
                           input logic toggle_mode, output aes_pkg::aes_block_t result);
    @(negedge clk_in);
    init_in = 1'b1;
    mode_in = mode;
    key_in  = key;
    data_in = data;
    @(negedge clk_in);
    init_in = 1'b0;
    // inputs may change freely once init has been sampled
    if (toggle_mode) begin
      key_in  = random_block();
      data_in = random_block();
    end
    while (!valid_out) begin
      if (toggle_mode) begin
        mode_in = ~mode_in;
      end
      @(negedge clk_in);
    end
    result = data_out;
    if (check_en) begin
      assert (result === expected)
        else begin
          data_errors++;
          $display("[ERROR] %s: expected %h, actual %h", name, expected, result);
        end
    end
  endtask

  // ========================================
  // watchdog
  // ========================================
  initial begin
    #(TIMEOUT_NS);
    $display("timeout: the DUT did not finish all operations in time");
    $display("Test failures found");
    $finish;
  end

  // ========================================
  // main sequence
  // ========================================
  initial begin
    aes_pkg::aes_block_t result;
    aes_pkg::aes_block_t cipher;
    aes_pkg::aes_block_t key;
    aes_pkg::aes_block_t plain;
    int                  proto_errors;

    void'($urandom(38));
    data_errors = 0;
    clk_in  = 1'b0;
    rst_in  = 1'b1;
    mode_in = `AES_ENCRYPT;
    init_in = 1'b0;
    data_in = '0;
    key_in  = '0;
    // reset for 4 cycles, released on a falling edge
    repeat (4) @(posedge clk_in);
    @(negedge clk_in);
    rst_in = 1'b0;

    // known answers, both directions
    run_block("enc kat a", `AES_ENCRYPT, KEY_A, PT_A, 1'b1, CT_A, 1'b0, result);
    run_block("enc kat b", `AES_ENCRYPT, KEY_B, PT_B, 1'b1, CT_B, 1'b0, result);
    run_block("dec kat a", `AES_DECRYPT, KEY_A, CT_A, 1'b1, PT_A, 1'b0, result);
    run_block("dec kat b", `AES_DECRYPT, KEY_B, CT_B, 1'b1, PT_B, 1'b0, result);

    // inverse cipher must undo the forward cipher
    for (int i = 0; i < 20; i++) begin
      key   = random_block();
      plain = random_block();
      run_block($sformatf("round trip %0d enc", i), `AES_ENCRYPT, key, plain,
                1'b0, '0, 1'b0, cipher);
      run_block($sformatf("round trip %0d dec", i), `AES_DECRYPT, key, cipher,
                1'b1, plain, 1'b0, result);
    end

    // mode, key and data wiggle after init, result follows the latched mode
    run_block("mode latch enc", `AES_ENCRYPT, KEY_B, PT_B, 1'b1, CT_B, 1'b1, result);
    run_block("mode latch dec", `AES_DECRYPT, KEY_A, CT_A, 1'b1, PT_A, 1'b1, result);

    // let the last valid clear before reading the checker
    repeat (2) @(negedge clk_in);
    proto_errors = i_dut.i_assertions.fail_count;
    $display("errors: %0d data, %0d protocol", data_errors, proto_errors);
    if (data_errors == 0 && proto_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- bench/aes_core_assertions.sv
`timescale 1ns/100ps
`include "aes_defines.svh"

module aes_core_assertions (
  input logic                clk_in,
  input logic                rst_in,
  input logic                init_in,
  input logic                valid_out,
  input aes_pkg::aes_block_t data_out
);

  // count of failed protocol checks
  int fail_count;

  initial begin
    fail_count = 0;
  end

  // ========================================
  // valid pulse shape
  // ========================================
  // result strobe lasts exactly one cycle
  valid_single_cycle: assert property (@(posedge clk_in) disable iff (rst_in)
    valid_out |=> !valid_out)
    else begin
      $error("valid_out stayed high for more than one cycle");
      fail_count++;
    end

  // ========================================
  // fixed latency
  // ========================================
  // every init leads to valid after the fixed latency
  valid_after_init: assert property (@(posedge clk_in) disable iff (rst_in)
    init_in |-> ##(`AES_LATENCY) valid_out)
    else begin
      $error("valid_out did not follow init_in after the fixed latency");
      fail_count++;
    end

  // and valid never shows up without a matching init
  init_before_valid: assert property (@(posedge clk_in) disable iff (rst_in)
    $rose(valid_out) |-> $past(init_in, `AES_LATENCY))
    else begin
      $error("valid_out rose without an init_in at the fixed latency before");
      fail_count++;
    end

  // result fully defined while presented
  data_known: assert property (@(posedge clk_in) disable iff (rst_in)
    valid_out |-> !$isunknown(data_out))
    else begin
      $error("data_out has unknown bits while valid_out is high");
      fail_count++;
    end

  // ========================================
  // reset behavior
  // ========================================
  // synchronous reset takes hold at the first edge it is sampled on
  valid_low_in_reset: assert property (@(posedge clk_in)
    rst_in && $past(rst_in) |-> !valid_out)
    else begin
      $error("valid_out high during reset");
      fail_count++;
    end

  // first cycle out of reset
  valid_low_after_reset: assert property (@(posedge clk_in)
    $fell(rst_in) |-> !valid_out)
    else begin
      $error("valid_out high in the first cycle after reset");
      fail_count++;
    end

endmodule

bind aes_core aes_core_assertions i_assertions (
  .clk_in    (clk_in),
  .rst_in    (rst_in),
  .init_in   (init_in),
  .valid_out (valid_out),
  .data_out  (data_out)
);

//--- rtl/aes_core.sv
`timescale 1ns/100ps
`include "aes_defines.svh"

module aes_core (
  input  logic                clk_in,
  input  logic                rst_in,
  // 1 encrypts, 0 decrypts
  input  logic                mode_in,
  input  logic                init_in,
  input  aes_pkg::aes_block_t data_in,
  input  aes_pkg::aes_block_t key_in,
  output aes_pkg::aes_block_t data_out,
  output logic                valid_out
);

  // operation captured at init
  logic                mode_q;
  aes_pkg::aes_block_t data_q;

  // key memory side
  aes_pkg::aes_block_t round_key;
  aes_pkg::aes_round_t round_rd;
  logic                key_expanded;

  // sequencing
  logic                start_aes;
  aes_pkg::aes_round_t round_q;
  logic                next_round;
  logic                valid;

  // engine side
  logic                enc_init, dec_init;
  logic                next_round_enc, next_round_dec;
  logic                valid_enc, valid_dec;
  aes_pkg::aes_block_t data_enc, data_dec;

  // ========================================
  // mode muxing
  // ========================================
  assign enc_init = start_aes && (mode_q == `AES_ENCRYPT);
  assign dec_init = start_aes && (mode_q == `AES_DECRYPT);

  // decryption walks the key schedule from round key 10 down
  assign round_rd = (mode_q == `AES_ENCRYPT) ? round_q : `AES_NUM_ROUNDS - round_q;

  assign next_round = (mode_q == `AES_ENCRYPT) ? next_round_enc : next_round_dec;
  assign valid      = (mode_q == `AES_ENCRYPT) ? valid_enc : valid_dec;
  assign data_out   = (mode_q == `AES_ENCRYPT) ? data_enc : data_dec;
  assign valid_out  = valid;

  // ========================================
  // submodules
  // ========================================
  aes_key_memory i_key_memory (
    .clk_in           (clk_in),
    .rst_in           (rst_in),
    .init_in          (init_in),
    .key_in           (key_in),
    .round_rd         (round_rd),
    .key_out          (round_key),
    .key_expanded_out (key_expanded)
  );

  aes_encryption i_encryption (
    .clk_in         (clk_in),
    .rst_in         (rst_in),
    .init_in        (enc_init),
    .data_in        (data_q),
    .key_in         (round_key),
    .round_in       (round_q),
    .next_round_out (next_round_enc),
    .data_out       (data_enc),
    .valid_out      (valid_enc)
  );

  aes_decryption i_decryption (
    .clk_in         (clk_in),
    .rst_in         (rst_in),
    .init_in        (dec_init),
    .data_in        (data_q),
    .key_in         (round_key),
    .round_in       (round_q),
    .next_round_out (next_round_dec),
    .data_out       (data_dec),
    .valid_out      (valid_dec)
  );

  // start one cycle after the schedule is complete
  // round counter clears on valid, which wins over the last next_round
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      start_aes <= 1'b0;
      round_q   <= `AES_ROUND_INIT;
      mode_q    <= `AES_ENCRYPT;
    end else begin
      start_aes <= key_expanded;
      if (valid) begin
        round_q <= `AES_ROUND_INIT;
      end else if (next_round) begin
        round_q <= round_q + 4'd1;
      end
      if (init_in) begin
        mode_q <= mode_in;
      end
    end
  end

  // input block held for the engine
  always_ff @(posedge clk_in) begin
    if (init_in) begin
      data_q <= data_in;
    end
  end

endmodule

//--- rtl/aes_decryption.sv
`timescale 1ns/100ps
`include "aes_defines.svh"

module aes_decryption (
  input  logic                clk_in,
  input  logic                rst_in,
  input  logic                init_in,
  input  aes_pkg::aes_block_t data_in,
  input  aes_pkg::aes_block_t key_in,
  input  aes_pkg::aes_round_t round_in,
  output logic                next_round_out,
  output aes_pkg::aes_block_t data_out,
  output logic                valid_out
);

  // round state and run flag
  aes_pkg::aes_block_t state_q;
  logic                busy_q;
  logic                last_round;

  // per-byte intermediates, index 4*column + row
  logic [7:0] isr [16];
  logic [7:0] isb [16];
  logic [7:0] ak  [16];
  logic [7:0] imc [16];

  aes_pkg::aes_block_t added;
  aes_pkg::aes_block_t round_out;

  // ========================================
  // inverse round
  // ========================================
  always_comb begin
    // invshiftrows, row r rotates right by r columns
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        isr[4*c + r] = state_q[127 - 8*(4*((c - r + 4) % 4) + r) -: 8];
      end
    end
    // invsubbytes
    for (int i = 0; i < 16; i++) begin
      isb[i] = aes_pkg::inv_sub_byte(isr[i]);
    end
    // addroundkey comes before invmixcolumns here
    added = {isb[0], isb[1], isb[2], isb[3], isb[4], isb[5], isb[6], isb[7],
             isb[8], isb[9], isb[10], isb[11], isb[12], isb[13], isb[14], isb[15]}
            ^ key_in;
    for (int i = 0; i < 16; i++) begin
      ak[i] = added[127 - 8*i -: 8];
    end
    // invmixcolumns
    // row r is 14*a ^ 11*b ^ 13*c ^ 9*d starting from byte r
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        imc[4*c + r] = aes_pkg::gf_mul(ak[4*c + r], 8'h0e)
                     ^ aes_pkg::gf_mul(ak[4*c + (r + 1) % 4], 8'h0b)
                     ^ aes_pkg::gf_mul(ak[4*c + (r + 2) % 4], 8'h0d)
                     ^ aes_pkg::gf_mul(ak[4*c + (r + 3) % 4], 8'h09);
      end
    end
    // final round skips invmixcolumns
    for (int i = 0; i < 16; i++) begin
      round_out[127 - 8*i -: 8] = (round_in == `AES_NUM_ROUNDS) ? ak[i] : imc[i];
    end
  end

  assign last_round = busy_q && (round_in == `AES_NUM_ROUNDS);

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      busy_q <= 1'b0;
    end else if (init_in) begin
      busy_q <= 1'b1;
    end else if (last_round) begin
      busy_q <= 1'b0;
    end
  end

  // key_in is round key 10 on init, the core reads the schedule backwards
  always_ff @(posedge clk_in) begin
    if (init_in) begin
      state_q <= data_in ^ key_in;
    end else if (busy_q) begin
      state_q <= round_out;
    end
  end

  assign next_round_out = init_in || busy_q;
  // plaintext is the combinational output of the last inverse round
  assign data_out  = round_out;
  assign valid_out = last_round;

endmodule

//--- rtl/aes_encryption.sv
`timescale 1ns/100ps
`include "aes_defines.svh"

module aes_encryption (
  input  logic                clk_in,
  input  logic                rst_in,
  input  logic                init_in,
  input  aes_pkg::aes_block_t data_in,
  input  aes_pkg::aes_block_t key_in,
  input  aes_pkg::aes_round_t round_in,
  output logic                next_round_out,
  output aes_pkg::aes_block_t data_out,
  output logic                valid_out
);

  // round state and run flag
  aes_pkg::aes_block_t state_q;
  logic                busy_q;
  logic                last_round;

  // per-byte intermediates, index 4*column + row
  logic [7:0] sb [16];
  logic [7:0] sr [16];
  logic [7:0] x2 [16];
  logic [7:0] mc [16];

  aes_pkg::aes_block_t mixed;
  aes_pkg::aes_block_t round_out;

  // ========================================
  // forward round
  // ========================================
  always_comb begin
    // subbytes
    for (int i = 0; i < 16; i++) begin
      sb[i] = aes_pkg::sub_byte(state_q[127 - 8*i -: 8]);
    end
    // shiftrows, row r rotates left by r columns
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        sr[4*c + r] = sb[4*((c + r) % 4) + r];
      end
    end
    // doubled bytes feed mixcolumns
    for (int i = 0; i < 16; i++) begin
      x2[i] = aes_pkg::xtime(sr[i]);
    end
    // mixcolumns, 2*a ^ 3*b ^ c ^ d rotated down each row
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        mc[4*c + r] = x2[4*c + r] ^ x2[4*c + (r + 1) % 4] ^ sr[4*c + (r + 1) % 4]
                    ^ sr[4*c + (r + 2) % 4] ^ sr[4*c + (r + 3) % 4];
      end
    end
    // final round has no mixcolumns
    for (int i = 0; i < 16; i++) begin
      mixed[127 - 8*i -: 8] = (round_in == `AES_NUM_ROUNDS) ? sr[i] : mc[i];
    end
    round_out = mixed ^ key_in;
  end

  assign last_round = busy_q && (round_in == `AES_NUM_ROUNDS);

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      busy_q <= 1'b0;
    end else if (init_in) begin
      busy_q <= 1'b1;
    end else if (last_round) begin
      busy_q <= 1'b0;
    end
  end

  // initial addroundkey on init, then one round per cycle
  always_ff @(posedge clk_in) begin
    if (init_in) begin
      state_q <= data_in ^ key_in;
    end else if (busy_q) begin
      state_q <= round_out;
    end
  end

  // a round key is used on init and on every busy cycle
  assign next_round_out = init_in || busy_q;
  // round 10 result leaves straight from the round logic
  assign data_out  = round_out;
  assign valid_out = last_round;

endmodule

//--- rtl/aes_key_memory.sv
`timescale 1ns/100ps
`include "aes_defines.svh"

module aes_key_memory (
  input  logic                clk_in,
  input  logic                rst_in,
  input  logic                init_in,
  input  aes_pkg::aes_block_t key_in,
  input  aes_pkg::aes_round_t round_rd,
  output aes_pkg::aes_block_t key_out,
  output logic                key_expanded_out
);

  // expansion control
  logic                expanding_q;
  aes_pkg::aes_round_t wr_cnt_q;
  logic [7:0]          rcon_q;

  // key store and the most recent round key
  aes_pkg::aes_round_keys_t keys_q;
  aes_pkg::aes_block_t      prev_key_q;

  // next round key, built column by column
  aes_pkg::aes_word_t  temp;
  aes_pkg::aes_word_t  w0, w1, w2, w3;
  aes_pkg::aes_block_t next_key;

  // ========================================
  // one round of key schedule
  // ========================================
  always_comb begin
    // last column rotated, substituted and mixed with rcon
    temp = aes_pkg::sub_word(aes_pkg::rot_word(prev_key_q[31:0])) ^ {rcon_q, 24'h000000};
    w0 = prev_key_q[127:96] ^ temp;
    w1 = prev_key_q[95:64] ^ w0;
    w2 = prev_key_q[63:32] ^ w1;
    w3 = prev_key_q[31:0] ^ w2;
    next_key = {w0, w1, w2, w3};
  end

  // write counter walks 1..10, rcon doubles each step
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      expanding_q      <= 1'b0;
      wr_cnt_q         <= `AES_ROUND_INIT;
      rcon_q           <= 8'h01;
      key_expanded_out <= 1'b0;
    end else begin
      key_expanded_out <= 1'b0;
      if (init_in) begin
        expanding_q <= 1'b1;
        wr_cnt_q    <= 4'd1;
        rcon_q      <= 8'h01;
      end else if (expanding_q) begin
        wr_cnt_q <= wr_cnt_q + 4'd1;
        rcon_q   <= aes_pkg::xtime(rcon_q);
        // last write, flag done in the following cycle
        if (wr_cnt_q == `AES_NUM_ROUNDS) begin
          expanding_q      <= 1'b0;
          key_expanded_out <= 1'b1;
        end
      end
    end
  end

  // cipher key goes in as round key 0
  always_ff @(posedge clk_in) begin
    if (init_in) begin
      keys_q[0]  <= key_in;
      prev_key_q <= key_in;
    end else if (expanding_q) begin
      keys_q[wr_cnt_q] <= next_key;
      prev_key_q       <= next_key;
    end
  end

  // combinational read port
  assign key_out = keys_q[round_rd];

endmodule

//--- rtl/aes_pkg.sv
`include "aes_defines.svh"

package aes_pkg;

  // ========================================
  // types
  // ========================================
  // 128-bit state, byte 0 in the top bits as in the standard
  typedef logic [127:0] aes_block_t;
  // one 32-bit column of the state
  typedef logic [31:0] aes_word_t;
  // round index, 0 to 10
  typedef logic [3:0] aes_round_t;
  // eleven expanded round keys, index 0 is the cipher key
  typedef aes_block_t aes_round_keys_t [0:`AES_NUM_ROUNDS];

  // ========================================
  // s-box tables
  // ========================================
  // forward s-box, entry 0 is the leftmost byte
  localparam logic [0:255][7:0] SBOX = {
    64'h637c777bf26b6fc5, 64'h3001672bfed7ab76,
    64'hca82c97dfa5947f0, 64'hadd4a2af9ca472c0,
    64'hb7fd9326363ff7cc, 64'h34a5e5f171d83115,
    64'h04c723c31896059a, 64'h071280e2eb27b275,
    64'h09832c1a1b6e5aa0, 64'h523bd6b329e32f84,
    64'h53d100ed20fcb15b, 64'h6acbbe394a4c58cf,
    64'hd0efaafb434d3385, 64'h45f9027f503c9fa8,
    64'h51a3408f929d38f5, 64'hbcb6da2110fff3d2,
    64'hcd0c13ec5f974417, 64'hc4a77e3d645d1973,
    64'h60814fdc222a9088, 64'h46eeb814de5e0bdb,
    64'he0323a0a4906245c, 64'hc2d3ac629195e479,
    64'he7c8376d8dd54ea9, 64'h6c56f4ea657aae08,
    64'hba78252e1ca6b4c6, 64'he8dd741f4bbd8b8a,
    64'h703eb5664803f60e, 64'h613557b986c11d9e,
    64'he1f8981169d98e94, 64'h9b1e87e9ce5528df,
    64'h8ca1890dbfe64268, 64'h41992d0fb054bb16
  };

  // inverse s-box
  localparam logic [0:255][7:0] INV_SBOX = {
    64'h52096ad53036a538, 64'hbf40a39e81f3d7fb,
    64'h7ce339829b2fff87, 64'h348e4344c4dee9cb,
    64'h547b9432a6c2233d, 64'hee4c950b42fac34e,
    64'h082ea16628d924b2, 64'h765ba2496d8bd125,
    64'h72f8f66486689816, 64'hd4a45ccc5d65b692,
    64'h6c704850fdedb9da, 64'h5e154657a78d9d84,
    64'h90d8ab008cbcd30a, 64'hf7e45805b8b34506,
    64'hd02c1e8fca3f0f02, 64'hc1afbd0301138a6b,
    64'h3a9111414f67dcea, 64'h97f2cfcef0b4e673,
    64'h96ac7422e7ad3585, 64'he2f937e81c75df6e,
    64'h47f11a711d29c589, 64'h6fb7620eaa18be1b,
    64'hfc563e4bc6d27920, 64'h9adbc0fe78cd5af4,
    64'h1fdda8338807c731, 64'hb11210592780ec5f,
    64'h60517fa919b54a0d, 64'h2de57a9f93c99cef,
    64'ha0e03b4dae2af5b0, 64'hc8ebbb3c83539961,
    64'h172b047eba77d626, 64'he169146355210c7d
  };

  // ========================================
  // byte functions
  // ========================================
  function automatic logic [7:0] sub_byte(input logic [7:0] b);
    return SBOX[b];
  endfunction

  function automatic logic [7:0] inv_sub_byte(input logic [7:0] b);
    return INV_SBOX[b];
  endfunction

  // multiply by x in gf(2^8), reduction polynomial 0x11b
  function automatic logic [7:0] xtime(input logic [7:0] b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
  endfunction

  // general multiply, shift and add over the bits of b
  // only ever called with a constant b so it folds to a few xors
  function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] acc;
    logic [7:0] p;
    acc = 8'h00;
    p = a;
    for (int i = 0; i < 8; i++) begin
      if (b[i]) begin
        acc = acc ^ p;
      end
      p = xtime(p);
    end
    return acc;
  endfunction

  // ========================================
  // word functions for key expansion
  // ========================================
  // s-box on each byte of a column
  function automatic aes_word_t sub_word(input aes_word_t w);
    return {sub_byte(w[31:24]), sub_byte(w[23:16]),
            sub_byte(w[15:8]), sub_byte(w[7:0])};
  endfunction

  // cyclic left rotate by one byte
  function automatic aes_word_t rot_word(input aes_word_t w);
    return {w[23:0], w[31:24]};
  endfunction

endpackage

//--- include/aes_defines.svh
`ifndef AES_DEFINES_SVH
`define AES_DEFINES_SVH

// ========================================
// mode encodings, one bit each
// ========================================
`define AES_ENCRYPT 1'b1
`define AES_DECRYPT 1'b0

// ========================================
// round bookkeeping
// ========================================
// aes-128 has ten rounds after the initial key addition
`define AES_NUM_ROUNDS 4'd10
// value the round counter returns to when idle
`define AES_ROUND_INIT 4'd0

// cycles from the edge sampling init_in to the valid_out cycle
`define AES_LATENCY 22

`endif
